// ==== hw/divPkg.sv ====
`default_nettype none

package divPkg;

    // Operand width used by the top level
    parameter int DivWidth = 8;

    // Dividend, divisor, quotient or remainder
    typedef logic [DivWidth-1:0] wordT;

    // Signed partial remainder, one extra bit for the sign
    typedef logic [DivWidth:0] partialT;

    typedef enum logic [1:0] {
        Idle,
        Load,
        Iterate,
        Finish
    } seqStateT;

endpackage

`default_nettype wire

// ==== hw/divSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module divSequencer
    import divPkg::*;
#(
    parameter int dataWidth = DivWidth
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  start,
    output logic busy,
    output logic done,
    output logic load,
    output logic iterate,
    output logic finish
);

    localparam int stepWidth = $clog2(dataWidth + 1);

    seqStateT state;
    logic [stepWidth-1:0] stepCount;
    logic lastStep;

    assign lastStep = (stepCount == stepWidth'(dataWidth - 1));

    // Operands are taken on the accepting edge itself
    assign load    = (state == Idle) && start;
    assign iterate = (state == Iterate);
    assign finish  = (state == Finish);
    assign busy    = (state != Idle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= Idle;
            stepCount <= '0;
            done      <= 1'b0;
        end else begin
            done <= finish; // Lines up with result update
            case (state)
                Idle: begin
                    if (start) begin
                        state <= Load;
                    end
                end
                Load: begin
                    stepCount <= '0;
                    state     <= Iterate;
                end
                Iterate: begin
                    stepCount <= stepCount + 1'b1;
                    if (lastStep) begin
                        state <= Finish;
                    end
                end
                Finish: begin
                    state <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    stepBound: assert property (@(posedge clk) disable iff (rst)
        stepCount <= stepWidth'(dataWidth))
        else $error("step counter past dataWidth");

    loadFromIdle: assert property (@(posedge clk) disable iff (rst)
        load |-> (state == Idle) ##1 (state == Load))
        else $error("load outside of Idle exit");

endmodule

`default_nettype wire

// ==== hw/divTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module divTop
    import divPkg::*;
#(
    parameter int dataWidth = DivWidth
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  start,
    input  wordT dividend,
    input  wordT divisor,
    output logic busy,
    output logic done,
    output wordT quotient,
    output wordT remainder
);

    logic    load;
    logic    iterate;
    logic    finish;
    logic    shiftOut;
    logic    quotientBit;
    partialT partial;
    wordT    heldDivisor;
    wordT    quotientRaw;
    wordT    dividendSeen;

    // Kept for the divide by zero result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dividendSeen <= '0;
        end else if (load) begin
            dividendSeen <= dividend;
        end
    end

    divSequencer #(
        .dataWidth(dataWidth)
    ) i_divSequencer (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .busy   (busy),
        .done   (done),
        .load   (load),
        .iterate(iterate),
        .finish (finish)
    );

    remainderUnit #(
        .dataWidth(dataWidth)
    ) i_remainderUnit (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .iterate    (iterate),
        .divisor    (divisor),
        .shiftIn    (shiftOut),
        .quotientBit(quotientBit),
        .partial    (partial),
        .heldDivisor(heldDivisor)
    );

    quotientUnit #(
        .dataWidth(dataWidth)
    ) i_quotientUnit (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .iterate    (iterate),
        .dividend   (dividend),
        .quotientBit(quotientBit),
        .shiftOut   (shiftOut),
        .quotientRaw(quotientRaw)
    );

    resultSelect #(
        .dataWidth(dataWidth)
    ) i_resultSelect (
        .clk         (clk),
        .rst         (rst),
        .finish      (finish),
        .partial     (partial),
        .heldDivisor (heldDivisor),
        .quotientRaw (quotientRaw),
        .dividendSeen(dividendSeen),
        .quotient    (quotient),
        .remainder   (remainder)
    );

endmodule

`default_nettype wire

// ==== hw/quotientUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module quotientUnit
    import divPkg::*;
#(
    parameter int dataWidth = DivWidth
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load,
    input  wire                  iterate,
    input  wire  [dataWidth-1:0] dividend,
    input  wire                  quotientBit,
    output logic                 shiftOut,
    output logic [dataWidth-1:0] quotientRaw
);

    // Dividend bits leave the top as quotient bits enter the bottom
    logic [dataWidth-1:0] shiftReg;

    assign shiftOut    = shiftReg[dataWidth-1];
    assign quotientRaw = shiftReg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shiftReg <= '0;
        end else if (load) begin
            shiftReg <= dividend;
        end else if (iterate) begin
            shiftReg <= {shiftReg[dataWidth-2:0], quotientBit};
        end
    end

endmodule

`default_nettype wire

// ==== hw/remainderUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module remainderUnit
    import divPkg::*;
#(
    parameter int dataWidth = DivWidth
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  load,
    input  wire                  iterate,
    input  wire  [dataWidth-1:0] divisor,
    input  wire                  shiftIn,
    output logic                 quotientBit,
    output logic [dataWidth:0]   partial,
    output logic [dataWidth-1:0] heldDivisor
);

    logic [dataWidth:0] shifted;
    logic [dataWidth:0] nextPartial;
    logic [dataWidth:0] divisorExt;

    assign divisorExt = {1'b0, heldDivisor};
    assign shifted    = {partial[dataWidth-1:0], shiftIn}; // 2P + next dividend bit

    // Old sign picks add or subtract, wraps but lands in range
    always_comb begin
        if (partial[dataWidth]) begin
            nextPartial = shifted + divisorExt;
        end else begin
            nextPartial = shifted - divisorExt;
        end
    end

    assign quotientBit = ~nextPartial[dataWidth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            partial     <= '0;
            heldDivisor <= '0;
        end else if (load) begin
            partial     <= '0;
            heldDivisor <= divisor;
        end else if (iterate) begin
            partial <= nextPartial;
        end
    end

    loadClears: assert property (@(posedge clk) disable iff (rst)
        load |=> (partial == '0))
        else $error("partial remainder not cleared by load");

endmodule

`default_nettype wire

// ==== hw/resultSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultSelect
    import divPkg::*;
#(
    parameter int dataWidth = DivWidth
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  finish,
    input  wire  [dataWidth:0]   partial,
    input  wire  [dataWidth-1:0] heldDivisor,
    input  wire  [dataWidth-1:0] quotientRaw,
    input  wire  [dataWidth-1:0] dividendSeen,
    output logic [dataWidth-1:0] quotient,
    output logic [dataWidth-1:0] remainder
);

    logic [dataWidth:0] corrected;
    logic divByZero;

    assign divByZero = (heldDivisor == '0);

    // Negative remainder needs one restoring add
    always_comb begin
        if (partial[dataWidth]) begin
            corrected = partial + {1'b0, heldDivisor};
        end else begin
            corrected = partial;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (finish) begin
            if (divByZero) begin
                quotient  <= '1;
                remainder <= dividendSeen;
            end else begin
                quotient  <= quotientRaw;
                remainder <= corrected[dataWidth-1:0];
            end
        end
    end

    remBelowDivisor: assert property (@(posedge clk) disable iff (rst)
        (finish && !divByZero) |=> (remainder < heldDivisor))
        else $error("remainder not below divisor");

endmodule

`default_nettype wire

// ==== sources.f ====
hw/divPkg.sv
hw/divSequencer.sv
hw/remainderUnit.sv
hw/quotientUnit.sv
hw/resultSelect.sv
hw/divTop.sv
verification/divTb.sv

// ==== verification/divTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module divTb
    import divPkg::*;
;

    localparam int divCycles = DivWidth + 4; // start, load, iterations, finish, done
    localparam int maxCycles = 2 * 70 * divCycles + 320;
    localparam int busyLength = DivWidth + 2;

    logic clk;
    logic rst;
    logic start;
    wordT dividend;
    wordT divisor;
    logic busy;
    logic done;
    wordT quotient;
    wordT remainder;

    logic [31:0] lfsrState;
    int cycleCount;
    int errorCount;
    int testErrorBase;
    int testsRun;
    int testsFailed;

    divTop #(
        .dataWidth(DivWidth)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .done     (done),
        .quotient (quotient),
        .remainder(remainder)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= maxCycles) begin
            $display("timeout: run did not finish within %0d cycles", maxCycles);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic wordT randomWord();
        wordT w;
        for (int i = 0; i < DivWidth; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w[i] = lfsrState[0];
        end
        return w;
    endfunction

    task automatic waitCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic beginTest();
        testErrorBase = errorCount;
        testsRun++;
    endtask

    task automatic endTest(input string name);
        if (errorCount == testErrorBase) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - testErrorBase);
            testsFailed++;
        end
    endtask

    // Starts one division and waits for done; injectAt < 0 means no extra start
    task automatic runDivision(input wordT a, input wordT b, input int injectAt,
                               output wordT q, output wordT r, output int busyCycles);
        dividend = a;
        divisor  = b;
        start    = 1'b1;
        waitCycle();
        busyCycles = 0;
        while (!done) begin
            start = (busyCycles == injectAt);
            if (start) begin
                dividend = ~a; // Must be ignored while busy
                divisor  = ~b;
            end
            checkBit("busy while running", 1'b1, busy);
            busyCycles++;
            waitCycle();
        end
        start = 1'b0;
        checkBit("busy low with done", 1'b0, busy);
        q = quotient;
        r = remainder;
    endtask

    task automatic checkDivision(input wordT a, input wordT b);
        wordT q;
        wordT r;
        wordT expQ;
        wordT expR;
        int busyCycles;
        string tag;
        tag = $sformatf("%0d/%0d", a, b);
        if (b == 0) begin
            expQ = '1;
            expR = a;
        end else begin
            expQ = a / b;
            expR = a % b;
        end
        runDivision(a, b, -1, q, r, busyCycles);
        checkWord({tag, " quotient"}, expQ, q);
        checkWord({tag, " remainder"}, expR, r);
        checkCount({tag, " busy cycles"}, busyLength, busyCycles);
    endtask

    task automatic testReset();
        beginTest();
        checkBit("reset busy", 1'b0, busy);
        checkBit("reset done", 1'b0, done);
        checkWord("reset quotient", '0, quotient);
        checkWord("reset remainder", '0, remainder);
        endTest("reset");
    endtask

    task automatic testKnown();
        beginTest();
        checkDivision(8'd100, 8'd7);
        checkDivision(8'd255, 8'd1);
        checkDivision(8'd255, 8'd255);
        checkDivision(8'd5, 8'd9);
        checkDivision(8'd128, 8'd16);
        endTest("known divisions");
    endtask

    task automatic testDivZero();
        beginTest();
        checkDivision(8'd77, 8'd0);
        checkDivision(8'd0, 8'd0);
        endTest("divisor zero");
    endtask

    task automatic testRandom();
        wordT a;
        wordT b;
        beginTest();
        for (int i = 0; i < 50; i++) begin
            a = randomWord();
            b = randomWord();
            while (b == 0) begin
                b = randomWord();
            end
            checkDivision(a, b);
        end
        endTest("random operands");
    endtask

    task automatic testHandshake();
        wordT q;
        wordT r;
        int busyCycles;
        beginTest();
        runDivision(8'd200, 8'd13, 3, q, r, busyCycles); // Extra start mid run
        checkWord("ignored start quotient", 8'd15, q);
        checkWord("ignored start remainder", 8'd5, r);
        checkCount("ignored start busy cycles", busyLength, busyCycles);
        waitCycle();
        checkBit("done single cycle", 1'b0, done);
        checkBit("busy stays low", 1'b0, busy);
        checkWord("quotient held", 8'd15, quotient);
        checkWord("remainder held", 8'd5, remainder);
        endTest("handshake timing");
    endtask

    task automatic testBackToBack();
        beginTest();
        checkDivision(8'd250, 8'd6); // Returns in the done cycle
        checkDivision(8'd99, 8'd10);
        endTest("back-to-back starts");
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        dividend    = '0;
        divisor     = '0;
        lfsrState   = 32'h2a66;
        cycleCount  = 0;
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        waitCycle();

        testReset();
        testKnown();
        testDivZero();
        testRandom();
        testHandshake();
        testBackToBack();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
